//--- Makefile
# Verilator build and run of the peripheral subsystem testbench
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench into $(LOG), check the result"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f list.f --top-module tb_periph \
		--Mdir $(BUILD_DIR) -o Vtb_periph
	-./$(BUILD_DIR)/Vtb_periph > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/periph_stim.txt
# op test address data byte_enables expected, all but test in hex
# W write, R read, E unmapped (write if be set), G gp_i, O gp_o, I irq, T mtime, X, P, F
W 1 00100000 DEADBEEF F 00000000
W 1 00100004 12345678 F 00000000
W 1 001003FC A5A5A5A5 F 00000000
R 1 00100000 00000000 F DEADBEEF
R 1 00100004 00000000 F 12345678
R 1 001003FC 00000000 F A5A5A5A5
W 1 00100004 AABBCCDD 3 00000000
R 1 00100004 00000000 F 1234CCDD
W 1 00100004 99000000 8 00000000
R 1 00100004 00000000 F 9934CCDD
R 1 00101000 00000000 F DEADBEEF
X 1 00100010 00000000 6 00000000
W 2 80000000 12345678 F 00000000
R 2 80000000 00000000 F 00005678
W 2 80000000 000000AB 1 00000000
R 2 80000000 00000000 F 000056AB
O 2 80000000 00000000 0 000056AB
G 3 80000004 000000A5 0 00000000
R 3 80000004 00000000 F 000000A5
G 3 80000004 0000003C 0 00000000
R 3 80000004 00000000 F 0000003C
I 4 80002000 00000000 0 00000000
W 4 8000200C 00000000 F 00000000
W 4 80002008 00000000 F 00000000
I 4 80002000 00000000 0 00000001
W 4 8000200C FFFFFFFF F 00000000
I 4 80002000 00000000 0 00000000
T 4 80002000 00000000 F 00000000
E 5 40000000 00000000 0 00000000
E 5 40000000 11111111 F 00000000
R 5 00100000 00000000 F DEADBEEF
P 6 00100000 00000000 F DEADBEEF
P 6 80000000 00000000 F 000056AB
P 6 8000200C 00000000 F FFFFFFFF
P 6 00100004 00000000 F 9934CCDD
P 6 80000004 00000000 F 0000003C
F 6 00000000 00000000 0 00000000

//--- bench/tb_periph.sv
// ---------------------------------------------------------------------------
// Testbench for the peripheral subsystem: stim file reader, host bus driver,
// RAM, GPIO, timer, unmapped and back-to-back access checks
// ---------------------------------------------------------------------------
module tb_periph
  import soc_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int GpiWidth   = 8;
  localparam int GpoWidth   = 16;
  localparam int BusTimeout = 50;
  localparam int IrqTimeout = 40;

  logic                clk_sys_i;
  logic                rst_sys_ni;
  logic                host_req_i;
  logic                host_gnt_o;
  addr_t               host_addr_i;
  logic                host_we_i;
  be_t                 host_be_i;
  data_t               host_wdata_i;
  logic                host_rvalid_o;
  data_t               host_rdata_o;
  logic                host_err_o;
  logic [GpiWidth-1:0] gp_i;
  logic [GpoWidth-1:0] gp_o;
  logic                timer_irq_o;

  int    seed = 54711;
  bit    timed_out;
  int    test_errs;
  int    total_errs;
  int    n_pass;
  int    n_fail;
  addr_t pipe_addr [$];
  data_t pipe_exp  [$];

  periph_top #(.GpiWidth(GpiWidth), .GpoWidth(GpoWidth), .RamWords(1024)) UUT (
    .clk_sys_i, .rst_sys_ni, .host_req_i, .host_gnt_o, .host_addr_i, .host_we_i,
    .host_be_i, .host_wdata_i, .host_rvalid_o, .host_rdata_o, .host_err_o,
    .gp_i, .gp_o, .timer_irq_o
  );

  always #10 clk_sys_i = ~clk_sys_i;

  // Byte lanes with their enable set come from new_word
  function automatic data_t lane_merge(data_t old_word, data_t new_word, be_t be);
    data_t mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  function automatic string target_name(addr_t addr);
    device_e dev;
    if ((addr & RamMask) == RamBase) dev = DevRam;
    else if ((addr & GpioMask) == GpioBase) dev = DevGpio;
    else if ((addr & TimerMask) == TimerBase) dev = DevTimer;
    else return "unmapped";
    return dev.name();
  endfunction

  task automatic check_value(string name, data_t got, data_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      test_errs++;
      total_errs++;
    end
  endtask

  task automatic report_timeout(string what);
    $display("Timeout: %s did not arrive within %0d cycles", what, BusTimeout);
    timed_out = 1'b1;
    test_errs++;
    total_errs++;
  endtask

  task automatic bus_access(input logic we, input addr_t addr, input data_t wdata,
                            input be_t be, output data_t rdata, output logic err);
    int cnt;
    rdata = '0;
    err   = 1'b0;
    @(posedge clk_sys_i);
    #2;
    host_req_i   = 1'b1;
    host_we_i    = we;
    host_addr_i  = addr;
    host_be_i    = be;
    host_wdata_i = wdata;
    // Request stays up until grant is seen
    cnt = 0;
    @(negedge clk_sys_i);
    while (!host_gnt_o && cnt < BusTimeout) begin
      @(negedge clk_sys_i);
      cnt++;
    end
    if (!host_gnt_o) report_timeout("host_gnt_o");
    @(posedge clk_sys_i);
    #2;
    host_req_i = 1'b0;
    if (!timed_out) begin
      cnt = 0;
      @(negedge clk_sys_i);
      while (!host_rvalid_o && cnt < BusTimeout) begin
        @(negedge clk_sys_i);
        cnt++;
      end
      if (!host_rvalid_o) report_timeout("host_rvalid_o");
      rdata = host_rdata_o;
      err   = host_err_o;
    end
  endtask

  task automatic check_access(logic we, addr_t addr, data_t wdata, be_t be,
                              data_t exp_rdata, logic exp_err);
    data_t rdata;
    logic  err;
    bus_access(we, addr, wdata, be, rdata, err);
    if (!timed_out) begin
      check_value({"host_err_o from ", target_name(addr)}, 32'(err), 32'(exp_err));
      check_value({"host_rdata_o from ", target_name(addr)}, rdata, exp_rdata);
    end
  endtask

  // Random full word followed by a partial write over it
  task automatic random_merge_test(addr_t addr, be_t be);
    data_t first;
    data_t second;
    first  = $random(seed);
    second = $random(seed);
    check_access(1'b1, addr, first, 4'hF, '0, 1'b0);
    check_access(1'b1, addr, second, be, '0, 1'b0);
    check_access(1'b0, addr, '0, 4'hF, lane_merge(first, second, be), 1'b0);
  endtask

  // One read per cycle with each response one cycle after its grant
  task automatic issue_back_to_back();
    int n;
    n = pipe_addr.size();
    for (int i = 0; i <= n; i++) begin
      @(posedge clk_sys_i);
      #2;
      host_req_i  = i < n;
      host_we_i   = 1'b0;
      host_be_i   = 4'hF;
      host_addr_i = (i < n) ? pipe_addr[i] : '0;
      @(negedge clk_sys_i);
      if (i < n) check_value("host_gnt_o", 32'(host_gnt_o), 32'd1);
      if (i > 0) begin
        check_value("host_rvalid_o", 32'(host_rvalid_o), 32'd1);
        check_value("host_err_o", 32'(host_err_o), 32'd0);
        check_value({"host_rdata_o from ", target_name(pipe_addr[i-1])}, host_rdata_o,
                    pipe_exp[i-1]);
      end
    end
    pipe_addr.delete();
    pipe_exp.delete();
  endtask

  task automatic close_test(int t);
    if (test_errs == 0) begin
      n_pass++;
      $display("Test %0d passed", t);
    end else begin
      n_fail++;
      $display("Test %0d failed with %0d errors", t, test_errs);
    end
    test_errs = 0;
  endtask

  initial begin
    int    fd;
    int    cur_test;
    int    tnum;
    int    cnt;
    string line;
    string op;
    addr_t addr;
    data_t data;
    be_t   be;
    data_t exp;
    data_t lo_first;
    data_t lo_second;
    logic  err;
    clk_sys_i    = 1'b0;
    rst_sys_ni   = 1'b0;
    host_req_i   = 1'b0;
    host_addr_i  = '0;
    host_we_i    = 1'b0;
    host_be_i    = '0;
    host_wdata_i = '0;
    gp_i         = '0;
    repeat (5) @(posedge clk_sys_i);
    #2;
    rst_sys_ni = 1'b1;
    cur_test   = -1;
    fd = $fopen("bench/periph_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file bench/periph_stim.txt");
      total_errs++;
    end else begin
      while (!timed_out && $fgets(line, fd) != 0) begin
        if ($sscanf(line, "%s %d %h %h %h %h", op, tnum, addr, data, be, exp) == 6) begin
          if (tnum != cur_test) begin
            if (cur_test >= 0) close_test(cur_test);
            cur_test = tnum;
          end
          case (op.getc(0))
            "W": check_access(1'b1, addr, data, be, exp, 1'b0);
            "R": check_access(1'b0, addr, data, be, exp, 1'b0);
            "E": check_access(|be, addr, data, be, exp, 1'b1);
            "X": random_merge_test(addr, be);
            "F": issue_back_to_back();
            "P": begin
              pipe_addr.push_back(addr);
              pipe_exp.push_back(exp);
            end
            "G": begin
              @(posedge clk_sys_i);
              #2;
              gp_i = data[GpiWidth-1:0];
              repeat (4) @(posedge clk_sys_i);
            end
            "O": begin
              @(negedge clk_sys_i);
              check_value("gp_o", 32'(gp_o), exp);
            end
            "I": begin
              cnt = 0;
              @(negedge clk_sys_i);
              while (timer_irq_o !== exp[0] && cnt < IrqTimeout) begin
                @(negedge clk_sys_i);
                cnt++;
              end
              check_value("timer_irq_o", 32'(timer_irq_o), exp);
            end
            "T": begin
              bus_access(1'b0, addr, '0, 4'hF, lo_first, err);
              if (!timed_out) begin
                check_value({"host_err_o from ", target_name(addr)}, 32'(err), 32'd0);
              end
              bus_access(1'b0, addr, '0, 4'hF, lo_second, err);
              if (!timed_out) begin
                check_value({"host_err_o from ", target_name(addr)}, 32'(err), 32'd0);
                check_value("mtime low increase", 32'(lo_second > lo_first), 32'd1);
              end
            end
            default: begin
              $display("Unknown operation %s in the stimulus file", op);
              test_errs++;
              total_errs++;
            end
          endcase
        end
      end
      $fclose(fd);
      if (cur_test >= 0) close_test(cur_test);
    end
    $display("Tests passed: %0d, tests failed: %0d", n_pass, n_fail);
    if (total_errs == 0 && n_fail == 0 && n_pass > 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- design/bus_decoder.sv
// ---------------------------------------------------------------------------
// Address decoder: request routing, response mux and error response
// ---------------------------------------------------------------------------
module bus_decoder
  import soc_pkg::*;
(
  input  logic  clk_sys_i,
  input  logic  rst_sys_ni,

  input  logic  host_req_i,
  input  addr_t host_addr_i,
  input  logic  host_we_i,
  input  be_t   host_be_i,
  input  data_t host_wdata_i,
  output logic  host_gnt_o,
  output logic  host_rvalid_o,
  output data_t host_rdata_o,
  output logic  host_err_o,

  dev_bus_if.decoder ram_o,
  dev_bus_if.decoder gpio_o,
  dev_bus_if.decoder timer_o
);

  logic [NrDevices-1:0] hit;
  device_e              sel_d;
  device_e              sel_q;
  logic                 err_q;

  logic  dev_rvalid [NrDevices];
  data_t dev_rdata  [NrDevices];

  // Window match per device
  assign hit[DevRam]   = (host_addr_i & RamMask)   == RamBase;
  assign hit[DevGpio]  = (host_addr_i & GpioMask)  == GpioBase;
  assign hit[DevTimer] = (host_addr_i & TimerMask) == TimerBase;

  always_comb begin
    sel_d = DevRam;
    if (hit[DevGpio]) begin
      sel_d = DevGpio;
    end
    if (hit[DevTimer]) begin
      sel_d = DevTimer;
    end
  end

  // All devices answer in fixed time, so every request is granted at once
  assign host_gnt_o = host_req_i;

  assign ram_o.req     = host_req_i & hit[DevRam];
  assign ram_o.addr    = host_addr_i;
  assign ram_o.we      = host_we_i;
  assign ram_o.be      = host_be_i;
  assign ram_o.wdata   = host_wdata_i;

  assign gpio_o.req    = host_req_i & hit[DevGpio];
  assign gpio_o.addr   = host_addr_i;
  assign gpio_o.we     = host_we_i;
  assign gpio_o.be     = host_be_i;
  assign gpio_o.wdata  = host_wdata_i;

  assign timer_o.req   = host_req_i & hit[DevTimer];
  assign timer_o.addr  = host_addr_i;
  assign timer_o.we    = host_we_i;
  assign timer_o.be    = host_be_i;
  assign timer_o.wdata = host_wdata_i;

  // Remember the target of the access now in address phase
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      sel_q <= DevRam;
      err_q <= 1'b0;
    end else begin
      err_q <= host_req_i & ~(|hit);
      if (host_req_i) begin
        sel_q <= sel_d;
      end
    end
  end

  assign dev_rvalid[DevRam]   = ram_o.rvalid;
  assign dev_rvalid[DevGpio]  = gpio_o.rvalid;
  assign dev_rvalid[DevTimer] = timer_o.rvalid;
  assign dev_rdata[DevRam]    = ram_o.rdata;
  assign dev_rdata[DevGpio]   = gpio_o.rdata;
  assign dev_rdata[DevTimer]  = timer_o.rdata;

  // Unmapped access is answered here with err and zero data
  assign host_rvalid_o = err_q | dev_rvalid[sel_q];
  assign host_rdata_o  = err_q ? '0 : dev_rdata[sel_q];
  assign host_err_o    = err_q;

  a_one_device_req : assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    $onehot0({ram_o.req, gpio_o.req, timer_o.req}));

  // Holds only if every device keeps its one-cycle response
  a_rsp_follows_gnt : assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    host_gnt_o |=> host_rvalid_o);

endmodule

//--- design/dev_bus_if.sv
// ---------------------------------------------------------------------------
// Decoder-to-device link with decoder and device modports
// ---------------------------------------------------------------------------
interface dev_bus_if #(
  parameter int AddrWidth = 32,
  parameter int DataWidth = 32,
  parameter int BeWidth   = 4
);

  // Request phase, driven by the decoder
  logic                 req;
  logic [AddrWidth-1:0] addr;
  logic                 we;
  logic [BeWidth-1:0]   be;
  logic [DataWidth-1:0] wdata;

  // Response phase, one cycle after req
  logic                 rvalid;
  logic [DataWidth-1:0] rdata;

  modport decoder (
    output req, addr, we, be, wdata,
    input  rvalid, rdata
  );

  modport device (
    input  req, addr, we, be, wdata,
    output rvalid, rdata
  );

endinterface

//--- design/gpio_regs.sv
// ---------------------------------------------------------------------------
// GPIO output register and two-flop input synchronizer behind bus registers
// ---------------------------------------------------------------------------
module gpio_regs
  import soc_pkg::*;
#(
  parameter int GpiWidth = 8,
  parameter int GpoWidth = 16
) (
  input  logic                clk_sys_i,
  input  logic                rst_sys_ni,
  dev_bus_if.device           bus_i,
  input  logic [GpiWidth-1:0] gp_i,
  output logic [GpoWidth-1:0] gp_o
);

  logic [GpiWidth-1:0]    gpi_meta;
  logic [GpiWidth-1:0]    gpi_sync;
  logic [RegOffWidth-1:0] reg_off;
  data_t                  gpo_wr;
  data_t                  rd_word;

  assign reg_off = {bus_i.addr[RegOffWidth-1:2], 2'b00};
  assign gpo_wr  = merge_bytes(data_t'(gp_o), bus_i.wdata, bus_i.be);

  // gp_i is asynchronous to the bus clock
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gpi_meta <= '0;
      gpi_sync <= '0;
    end else begin
      gpi_meta <= gp_i;
      gpi_sync <= gpi_meta;
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gp_o         <= '0;
      bus_i.rvalid <= 1'b0;
    end else begin
      bus_i.rvalid <= bus_i.req;
      if (bus_i.req && bus_i.we && reg_off == GpioOutOffset) begin
        gp_o <= gpo_wr[GpoWidth-1:0];
      end
    end
  end

  always_comb begin
    rd_word = '0;
    case (reg_off)
      GpioOutOffset: rd_word = data_t'(gp_o);
      GpioInOffset:  rd_word = data_t'(gpi_sync);
      default:       rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_sys_i) begin
    if (bus_i.req) begin
      bus_i.rdata <= bus_i.we ? '0 : rd_word;
    end
  end

endmodule

//--- design/periph_top.sv
// ---------------------------------------------------------------------------
// Peripheral subsystem top: decoder, RAM, GPIO and timer on one host port
// ---------------------------------------------------------------------------
module periph_top
  import soc_pkg::*;
#(
  parameter int GpiWidth = 8,
  parameter int GpoWidth = 16,
  parameter int RamWords = 1024
) (
  input  logic                clk_sys_i,
  input  logic                rst_sys_ni,

  input  logic                host_req_i,
  output logic                host_gnt_o,
  input  addr_t               host_addr_i,
  input  logic                host_we_i,
  input  be_t                 host_be_i,
  input  data_t               host_wdata_i,
  output logic                host_rvalid_o,
  output data_t               host_rdata_o,
  output logic                host_err_o,

  input  logic [GpiWidth-1:0] gp_i,
  output logic [GpoWidth-1:0] gp_o,
  output logic                timer_irq_o
);

  // One link per device
  dev_bus_if #(.AddrWidth(AddrWidth), .DataWidth(DataWidth), .BeWidth(BeWidth)) ram_bus ();
  dev_bus_if #(.AddrWidth(AddrWidth), .DataWidth(DataWidth), .BeWidth(BeWidth)) gpio_bus ();
  dev_bus_if #(.AddrWidth(AddrWidth), .DataWidth(DataWidth), .BeWidth(BeWidth)) timer_bus ();

  bus_decoder u_decoder (
    .clk_sys_i     (clk_sys_i),
    .rst_sys_ni    (rst_sys_ni),
    .host_req_i    (host_req_i),
    .host_addr_i   (host_addr_i),
    .host_we_i     (host_we_i),
    .host_be_i     (host_be_i),
    .host_wdata_i  (host_wdata_i),
    .host_gnt_o    (host_gnt_o),
    .host_rvalid_o (host_rvalid_o),
    .host_rdata_o  (host_rdata_o),
    .host_err_o    (host_err_o),
    .ram_o         (ram_bus),
    .gpio_o        (gpio_bus),
    .timer_o       (timer_bus)
  );

  ram_sp #(
    .RamWords (RamWords)
  ) u_ram (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .bus_i      (ram_bus)
  );

  gpio_regs #(
    .GpiWidth (GpiWidth),
    .GpoWidth (GpoWidth)
  ) u_gpio (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .bus_i      (gpio_bus),
    .gp_i       (gp_i),
    .gp_o       (gp_o)
  );

  timer_regs u_timer (
    .clk_sys_i   (clk_sys_i),
    .rst_sys_ni  (rst_sys_ni),
    .bus_i       (timer_bus),
    .timer_irq_o (timer_irq_o)
  );

endmodule

//--- design/ram_sp.sv
// ---------------------------------------------------------------------------
// Single-port word RAM with byte-enable writes
// ---------------------------------------------------------------------------
module ram_sp
  import soc_pkg::*;
#(
  parameter int RamWords = 1024
) (
  input logic       clk_sys_i,
  input logic       rst_sys_ni,
  dev_bus_if.device bus_i
);

  localparam int IdxWidth = $clog2(RamWords);

  data_t               mem [RamWords];
  logic [IdxWidth-1:0] idx;

  // Upper address bits alias within the window
  assign idx = bus_i.addr[IdxWidth+1:2];

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      bus_i.rvalid <= 1'b0;
    end else begin
      bus_i.rvalid <= bus_i.req;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (bus_i.req && bus_i.we) begin
      mem[idx] <= merge_bytes(mem[idx], bus_i.wdata, bus_i.be);
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_sys_i) begin
    if (bus_i.req) begin
      if (bus_i.we) begin
        bus_i.rdata <= '0;
      end else begin
        bus_i.rdata <= mem[idx];
      end
    end
  end

  a_rvalid_after_req : assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    bus_i.rvalid |-> $past(bus_i.req));

endmodule

//--- design/soc_pkg.sv
// ---------------------------------------------------------------------------
// Peripheral subsystem package: bus widths and types, device enumeration,
// address map, register offsets and the byte-lane merge helper
// ---------------------------------------------------------------------------
package soc_pkg;

  // Bus geometry
  localparam int AddrWidth = 32;
  localparam int DataWidth = 32;
  localparam int BeWidth   = DataWidth / 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [BeWidth-1:0]   be_t;

  // Devices behind the decoder
  typedef enum logic [1:0] {
    DevRam   = 2'd0,
    DevGpio  = 2'd1,
    DevTimer = 2'd2
  } device_e;

  localparam int NrDevices = 3;

  // Address windows
  // Each mask is the complement of the window size minus one
  localparam addr_t RamBase   = 32'h0010_0000;
  localparam addr_t RamMask   = ~addr_t'(64 * 1024 - 1);
  localparam addr_t GpioBase  = 32'h8000_0000;
  localparam addr_t GpioMask  = ~addr_t'(4 * 1024 - 1);
  localparam addr_t TimerBase = 32'h8000_2000;
  localparam addr_t TimerMask = ~addr_t'(4 * 1024 - 1);

  // Register offsets inside a 4 KiB device window
  localparam int RegOffWidth = 12;

  localparam logic [RegOffWidth-1:0] GpioOutOffset      = 12'h000;
  localparam logic [RegOffWidth-1:0] GpioInOffset       = 12'h004;
  localparam logic [RegOffWidth-1:0] TimerMtimeLoOffset = 12'h000;
  localparam logic [RegOffWidth-1:0] TimerMtimeHiOffset = 12'h004;
  localparam logic [RegOffWidth-1:0] TimerCmpLoOffset   = 12'h008;
  localparam logic [RegOffWidth-1:0] TimerCmpHiOffset   = 12'h00C;

  // Replace the byte lanes of old_word whose enable is set
  function automatic data_t merge_bytes(data_t old_word, data_t new_word, be_t be);
    data_t res;
    res = old_word;
    for (int i = 0; i < BeWidth; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return res;
  endfunction

endpackage

//--- design/timer_regs.sv
// ---------------------------------------------------------------------------
// 64-bit machine timer, 64-bit compare register and compare interrupt
// ---------------------------------------------------------------------------
module timer_regs
  import soc_pkg::*;
(
  input  logic      clk_sys_i,
  input  logic      rst_sys_ni,
  dev_bus_if.device bus_i,
  output logic      timer_irq_o
);

  logic [63:0]            mtime;
  logic [63:0]            mtimecmp;
  logic [RegOffWidth-1:0] reg_off;
  logic                   wr_en;
  data_t                  rd_word;

  assign reg_off = {bus_i.addr[RegOffWidth-1:2], 2'b00};
  assign wr_en   = bus_i.req & bus_i.we;

  // Free-running counter with one half replaced by a bus write
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtime <= '0;
    end else if (wr_en && reg_off == TimerMtimeLoOffset) begin
      mtime <= {mtime[63:32], merge_bytes(mtime[31:0], bus_i.wdata, bus_i.be)};
    end else if (wr_en && reg_off == TimerMtimeHiOffset) begin
      mtime <= {merge_bytes(mtime[63:32], bus_i.wdata, bus_i.be), mtime[31:0]};
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  // All ones at reset keeps the interrupt quiet
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtimecmp <= '1;
    end else if (wr_en && reg_off == TimerCmpLoOffset) begin
      mtimecmp[31:0] <= merge_bytes(mtimecmp[31:0], bus_i.wdata, bus_i.be);
    end else if (wr_en && reg_off == TimerCmpHiOffset) begin
      mtimecmp[63:32] <= merge_bytes(mtimecmp[63:32], bus_i.wdata, bus_i.be);
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      timer_irq_o  <= 1'b0;
      bus_i.rvalid <= 1'b0;
    end else begin
      timer_irq_o  <= mtime >= mtimecmp;
      bus_i.rvalid <= bus_i.req;
    end
  end

  always_comb begin
    rd_word = '0;
    case (reg_off)
      TimerMtimeLoOffset: rd_word = mtime[31:0];
      TimerMtimeHiOffset: rd_word = mtime[63:32];
      TimerCmpLoOffset:   rd_word = mtimecmp[31:0];
      TimerCmpHiOffset:   rd_word = mtimecmp[63:32];
      default:            rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_sys_i) begin
    if (bus_i.req) begin
      bus_i.rdata <= bus_i.we ? '0 : rd_word;
    end
  end

  // Compare register comes out of reset ahead of mtime
  a_irq_low_after_reset : assert property (@(posedge clk_sys_i)
    $rose(rst_sys_ni) |=> !timer_irq_o);

endmodule

//--- list.f
design/soc_pkg.sv
design/dev_bus_if.sv
design/bus_decoder.sv
design/ram_sp.sv
design/gpio_regs.sv
design/timer_regs.sv
design/periph_top.sv
bench/tb_periph.sv
